// File: demodPkg.sv
// Any mode outside the three special codes runs the legacy path, and misc offsets are even half-word addresses
package demodPkg;

    // ******************************
    // Widths
    // ******************************
    localparam int addrWidth = 12;
    localparam int busWidth  = 16;
    localparam int symWidth  = 18;
    localparam int dacWidth  = 14;
    localparam int modeWidth = 4;
    localparam int selWidth  = 4;

    // Demodulator modes needing special routing
    localparam logic [modeWidth-1:0] modeMultiH     = 4'd8;
    localparam logic [modeWidth-1:0] modePcmTrellis = 4'd9;
    localparam logic [modeWidth-1:0] modeSoqpsk     = 4'd10;

    // DAC select codes served by the trellis decoders
    localparam logic [selWidth-1:0] dacSelTrellisI     = 4'd12;
    localparam logic [selWidth-1:0] dacSelTrellisQ     = 4'd13;
    localparam logic [selWidth-1:0] dacSelTrellisPhErr = 4'd14;
    localparam logic [selWidth-1:0] dacSelTrellisIndex = 4'd15;

    // ******************************
    // Misc register map
    // ******************************
    localparam logic [7:0] miscPage = 8'hF0;

    localparam logic [3:0] offVersionLo = 4'h0;
    localparam logic [3:0] offVersionHi = 4'h2;
    localparam logic [3:0] offClockLo   = 4'h4;
    localparam logic [3:0] offClockHi   = 4'h6;
    localparam logic [3:0] offMode      = 4'h8;
    localparam logic [3:0] offDacSel    = 4'hA;
    localparam logic [3:0] offReset     = 4'hC;

    // Core reset pulse length in clocks
    localparam int coreResetCycles = 6;

    // ******************************
    // Struct types
    // ******************************
    typedef struct packed {
        logic                 cs;
        logic                 rd;
        logic                 wr;
        logic [addrWidth-1:0] addr;
        logic [busWidth-1:0]  wrData;
    } busReqT;

    // Legacy demod symbol outputs
    typedef struct packed {
        logic                iSymEn;
        logic                iSym2xEn;
        logic                trellisSymSync;
        logic                iBit;
        logic                qBit;
        logic [symWidth-1:0] iSym;
        logic [symWidth-1:0] qSym;
    } demodSymT;

    typedef struct packed {
        logic                symEn;
        logic                sym2xEn;
        logic [symWidth-1:0] iSym;
        logic [symWidth-1:0] qSym;
    } symFeedT;

    // Decoder result with the hard bit as decision
    typedef struct packed {
        logic symEn;
        logic sym2xEn;
        logic decision;
    } trellisResT;

    typedef struct packed {
        logic                sync;
        logic [symWidth-1:0] data;
    } dacSrcT;

    typedef struct packed {
        logic symEn;
        logic sym2xEn;
        logic iData;
        logic qData;
    } dataOutT;

endpackage

// File: miscRegs.sv
// Requests last one cycle with no wait states, and coreResetCycles must be at least 2
`timescale 1ns/10ps

module miscRegs #(
    parameter logic [demodPkg::busWidth-1:0] verNumber = 16'h0000
) (
    input  logic                                ck933,
    input  logic                                clockCounterEn,
    input  demodPkg::busReqT                    busReq,
    output logic [demodPkg::busWidth-1:0]       busRdData,
    output logic [demodPkg::modeWidth-1:0]      demodMode,
    output logic [2:0][demodPkg::selWidth-1:0]  dacSel,
    output logic                                coreReset
);

    localparam int resetCntWidth = $clog2(demodPkg::coreResetCycles);

    logic                          miscHit;
    logic [3:0]                    offset;
    logic                          wrEn;
    logic                          rdEn;
    logic                          anyRd;
    logic [31:0]                   clockCounter;
    logic [15:0]                   clockHoldHi;
    logic [resetCntWidth-1:0]      resetCount;
    logic [demodPkg::busWidth-1:0] rdMux;

    // ******************************
    // Address decode
    // ******************************
    assign miscHit = busReq.cs && (busReq.addr[demodPkg::addrWidth-1:4] == demodPkg::miscPage);
    assign offset  = busReq.addr[3:0];
    assign wrEn    = miscHit && busReq.wr;
    assign rdEn    = miscHit && busReq.rd;
    // Reads anywhere on the bus refresh the read data
    assign anyRd   = busReq.cs && busReq.rd;

    // Mode and DAC select registers
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodMode <= '0;
            dacSel    <= '0;
        end else if (wrEn) begin
            case (offset)
                demodPkg::offMode:   demodMode <= busReq.wrData[demodPkg::modeWidth-1:0];
                demodPkg::offDacSel: dacSel <= busReq.wrData[3*demodPkg::selWidth-1:0];
                default: ;
            endcase
        end
    end

    // ******************************
    // Clock counter
    // ******************************
    // Write to clock low restarts the count, read of clock low snapshots it
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            clockCounter <= '0;
            clockHoldHi  <= '0;
        end else begin
            if (wrEn && (offset == demodPkg::offClockLo)) begin
                clockCounter <= '0;
            end else begin
                clockCounter <= clockCounter + 32'd1;
            end
            if (rdEn && (offset == demodPkg::offClockLo)) begin
                clockHoldHi <= clockCounter[31:16];
            end
        end
    end

    // ******************************
    // Core reset stretcher
    // ******************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            coreReset  <= 1'b0;
            resetCount <= '0;
        end else if (rdEn && (offset == demodPkg::offReset)) begin
            coreReset  <= 1'b1;
            resetCount <= resetCntWidth'(demodPkg::coreResetCycles - 1);
        end else if (resetCount != '0) begin
            resetCount <= resetCount - 1'b1;
        end else begin
            coreReset <= 1'b0;
        end
    end

    // ******************************
    // Read data
    // ******************************
    always_comb begin
        rdMux = '0;
        if (miscHit) begin
            case (offset)
                demodPkg::offVersionLo: rdMux = '0;
                demodPkg::offVersionHi: rdMux = verNumber;
                // Low half comes straight from the counter being captured
                demodPkg::offClockLo:   rdMux = clockCounter[15:0];
                demodPkg::offClockHi:   rdMux = clockHoldHi;
                demodPkg::offMode: begin
                    rdMux = {{(demodPkg::busWidth - demodPkg::modeWidth){1'b0}}, demodMode};
                end
                demodPkg::offDacSel: begin
                    rdMux = {{(demodPkg::busWidth - 3*demodPkg::selWidth){1'b0}}, dacSel};
                end
                default: rdMux = '0;
            endcase
        end
    end

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            busRdData <= '0;
        end else if (anyRd) begin
            busRdData <= rdMux;
        end
    end

endmodule

// File: symbolRouter.sv
// Mode changes act on the next sample, and the trellis result path is one stage longer than legacy
`timescale 1ns/10ps

module symbolRouter (
    input  logic                           ck933,
    input  logic                           clockCounterEn,
    input  logic [demodPkg::modeWidth-1:0] demodMode,
    input  demodPkg::demodSymT             demodSym,
    input  demodPkg::trellisResT           pcmRes,
    input  demodPkg::trellisResT           soqpskRes,
    output demodPkg::symFeedT              pcmFeed,
    output demodPkg::symFeedT              soqpskFeed,
    output demodPkg::symFeedT              multiHFeed,
    output demodPkg::dataOutT              dataOut
);

    logic                 pcmMode;
    logic                 soqpskMode;
    logic                 multiHMode;
    logic                 trellisMode;
    demodPkg::trellisResT trellisRes;

    // Enables pass only on the feed whose mode is active
    function automatic demodPkg::symFeedT gateFeed(input demodPkg::demodSymT sym,
                                                   input logic modeMatch);
        demodPkg::symFeedT feed;
        feed.symEn   = sym.trellisSymSync & modeMatch;
        feed.sym2xEn = sym.iSym2xEn & modeMatch;
        feed.iSym    = sym.iSym;
        feed.qSym    = sym.qSym;
        return feed;
    endfunction

    assign pcmMode     = (demodMode == demodPkg::modePcmTrellis);
    assign soqpskMode  = (demodMode == demodPkg::modeSoqpsk);
    assign multiHMode  = (demodMode == demodPkg::modeMultiH);
    assign trellisMode = pcmMode || soqpskMode;

    // ******************************
    // Decoder feeds
    // ******************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            pcmFeed    <= '0;
            soqpskFeed <= '0;
            multiHFeed <= '0;
        end else begin
            pcmFeed    <= gateFeed(demodSym, pcmMode);
            soqpskFeed <= gateFeed(demodSym, soqpskMode);
            multiHFeed <= gateFeed(demodSym, multiHMode);
        end
    end

    // Reclock of the active decoder result
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            trellisRes <= '0;
        end else begin
            trellisRes <= pcmMode ? pcmRes : soqpskRes;
        end
    end

    // ******************************
    // Final data outputs
    // ******************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dataOut <= '0;
        end else if (trellisMode) begin
            dataOut.symEn   <= trellisRes.symEn;
            dataOut.sym2xEn <= trellisRes.sym2xEn;
            // Single decision drives both rails
            dataOut.iData   <= trellisRes.decision;
            dataOut.qData   <= trellisRes.decision;
        end else begin
            dataOut.symEn   <= demodSym.iSymEn;
            dataOut.sym2xEn <= demodSym.iSym2xEn;
            dataOut.iData   <= demodSym.iBit;
            dataOut.qData   <= demodSym.qBit;
        end
    end

endmodule

// File: dacRouter.sv
// Samples are truncated to the top 14 bits without rounding, and ports hold between syncs
`timescale 1ns/10ps

module dacRouter #(
    parameter int numDacs = 3
) (
    input  logic                                      ck933,
    input  logic                                      clockCounterEn,
    input  logic [demodPkg::modeWidth-1:0]            demodMode,
    input  logic [numDacs-1:0][demodPkg::selWidth-1:0] dacSel,
    input  demodPkg::dacSrcT [numDacs-1:0]            demodDac,
    input  demodPkg::dacSrcT [numDacs-1:0]            pcmDac,
    input  demodPkg::dacSrcT [numDacs-1:0]            soqpskDac,
    output logic [numDacs-1:0][demodPkg::dacWidth-1:0] dacData
);

    logic                              pcmMode;
    demodPkg::dacSrcT [numDacs-1:0]    srcMux;
    demodPkg::dacSrcT [numDacs-1:0]    dacReg;

    function automatic logic isTrellisSel(input logic [demodPkg::selWidth-1:0] sel);
        logic hit;
        case (sel)
            demodPkg::dacSelTrellisI,
            demodPkg::dacSelTrellisQ,
            demodPkg::dacSelTrellisPhErr,
            demodPkg::dacSelTrellisIndex: hit = 1'b1;
            default:                      hit = 1'b0;
        endcase
        return hit;
    endfunction

    // SOQPSK decoder owns the trellis source outside PCM mode
    assign pcmMode = (demodMode == demodPkg::modePcmTrellis);

    // ******************************
    // Source select
    // ******************************
    always_comb begin
        for (int ch = 0; ch < numDacs; ch++) begin
            if (!isTrellisSel(dacSel[ch])) begin
                srcMux[ch] = demodDac[ch];
            end else if (pcmMode) begin
                srcMux[ch] = pcmDac[ch];
            end else begin
                srcMux[ch] = soqpskDac[ch];
            end
        end
    end

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dacReg <= '0;
        end else begin
            dacReg <= srcMux;
        end
    end

    // ******************************
    // DAC port registers
    // ******************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dacData <= '0;
        end else begin
            for (int ch = 0; ch < numDacs; ch++) begin
                if (dacReg[ch].sync) begin
                    dacData[ch] <= dacReg[ch].data[demodPkg::symWidth-1 -: demodPkg::dacWidth];
                end
            end
        end
    end

endmodule

// File: demodRouter.sv
// numDacs must stay at 3 since the select register holds exactly three DAC codes
`timescale 1ns/10ps

module demodRouter #(
    parameter logic [demodPkg::busWidth-1:0] verNumber = 16'h0103,
    parameter int                            numDacs   = 3
) (
    input  logic                                       ck933,
    input  logic                                       clockCounterEn,

    // Processor bus
    input  demodPkg::busReqT                           busReq,
    output logic [demodPkg::busWidth-1:0]              busRdData,

    // Core control
    output logic [demodPkg::modeWidth-1:0]             demodMode,
    output logic                                       coreReset,

    // Symbol paths
    input  demodPkg::demodSymT                         demodSym,
    input  demodPkg::trellisResT                       pcmRes,
    input  demodPkg::trellisResT                       soqpskRes,
    output demodPkg::symFeedT                          pcmFeed,
    output demodPkg::symFeedT                          soqpskFeed,
    output demodPkg::symFeedT                          multiHFeed,
    output demodPkg::dataOutT                          dataOut,

    // DAC paths
    input  demodPkg::dacSrcT [numDacs-1:0]             demodDac,
    input  demodPkg::dacSrcT [numDacs-1:0]             pcmDac,
    input  demodPkg::dacSrcT [numDacs-1:0]             soqpskDac,
    output logic [numDacs-1:0][demodPkg::dacWidth-1:0] dacData
);

    logic [numDacs-1:0][demodPkg::selWidth-1:0] dacSel;

    // ******************************
    // Register space
    // ******************************
    miscRegs #(
        .verNumber(verNumber)
    ) i_miscRegs (
        .ck933         (ck933),
        .clockCounterEn(clockCounterEn),
        .busReq        (busReq),
        .busRdData     (busRdData),
        .demodMode     (demodMode),
        .dacSel        (dacSel),
        .coreReset     (coreReset)
    );

    // ******************************
    // Symbol and data routing
    // ******************************
    symbolRouter i_symbolRouter (
        .ck933         (ck933),
        .clockCounterEn(clockCounterEn),
        .demodMode     (demodMode),
        .demodSym      (demodSym),
        .pcmRes        (pcmRes),
        .soqpskRes     (soqpskRes),
        .pcmFeed       (pcmFeed),
        .soqpskFeed    (soqpskFeed),
        .multiHFeed    (multiHFeed),
        .dataOut       (dataOut)
    );

    // DAC source routing
    dacRouter #(
        .numDacs(numDacs)
    ) i_dacRouter (
        .ck933         (ck933),
        .clockCounterEn(clockCounterEn),
        .demodMode     (demodMode),
        .dacSel        (dacSel),
        .demodDac      (demodDac),
        .pcmDac        (pcmDac),
        .soqpskDac     (soqpskDac),
        .dacData       (dacData)
    );

endmodule

// File: demodRouterTbTable.svh
// Rows run in order with no gap, so idle counts set the exact distance between accesses
// Columns: action, address or mode, write data / expected read / DAC select, count, latency
// Stream rows take the mode in the address column and the select word in the data column
localparam int tableLen = 27;

localparam rowT stimTable [0:tableLen-1] = '{
    // Register map
    '{actRead,      12'hF02, 16'h0103, 8'd0,  2'd1},
    '{actRead,      12'hF00, 16'h0000, 8'd0,  2'd1},
    '{actWrite,     12'hF08, 16'h0005, 8'd0,  2'd0},
    '{actRead,      12'hF08, 16'h0005, 8'd0,  2'd1},
    '{actWrite,     12'hF0A, 16'hAC3F, 8'd0,  2'd0},
    // Only the low 12 bits hold select codes
    '{actRead,      12'hF0A, 16'h0C3F, 8'd0,  2'd1},
    '{actRead,      12'h123, 16'h0000, 8'd0,  2'd1},
    '{actRead,      12'hF02, 16'h0103, 8'd0,  2'd1},
    '{actRead,      12'hF0E, 16'h0000, 8'd0,  2'd1},
    // Clock counter reads return the number of idle cycles before them
    '{actWrite,     12'hF04, 16'h0000, 8'd0,  2'd0},
    '{actIdle,      12'h000, 16'h0000, 8'd5,  2'd0},
    '{actRead,      12'hF04, 16'h0005, 8'd0,  2'd1},
    '{actRead,      12'hF06, 16'h0000, 8'd0,  2'd1},
    '{actWrite,     12'hF04, 16'h0000, 8'd0,  2'd0},
    '{actIdle,      12'h000, 16'h0000, 8'd12, 2'd0},
    '{actRead,      12'hF04, 16'h000C, 8'd0,  2'd1},
    '{actWrite,     12'hF04, 16'h0000, 8'd0,  2'd0},
    '{actRead,      12'hF04, 16'h0000, 8'd0,  2'd1},
    // Core reset pulse length
    '{actCoreReset, 12'hF0C, 16'd6,    8'd0,  2'd1},
    // PCM, SOQPSK, multi-h, legacy, then mixed selects
    '{actStream,    12'h009, 16'h0C3F, 8'd16, 2'd2},
    '{actStream,    12'h00A, 16'h05ED, 8'd16, 2'd2},
    '{actStream,    12'h008, 16'h0C3F, 8'd16, 2'd1},
    '{actStream,    12'h003, 16'h05ED, 8'd16, 2'd1},
    '{actStream,    12'h009, 16'h05ED, 8'd12, 2'd2},
    '{actStream,    12'h000, 16'h0FFF, 8'd12, 2'd1},
    '{actRead,      12'hF08, 16'h0000, 8'd0,  2'd1},
    '{actRead,      12'hF0A, 16'h0FFF, 8'd0,  2'd1}
};

// File: demodRouterTb.sv
// Inputs change on falling edges and rest at zero between rows, so DAC syncs stay low outside streams
`timescale 1ns/10ps

module demodRouterTb;

    localparam int clockPeriod = 4;
    localparam int resetCycles = 8;
    localparam int numDacs     = 3;
    localparam int maxStream   = 64;

    localparam logic [2:0] actWrite     = 3'd0;
    localparam logic [2:0] actRead      = 3'd1;
    localparam logic [2:0] actIdle      = 3'd2;
    localparam logic [2:0] actCoreReset = 3'd3;
    localparam logic [2:0] actStream    = 3'd4;

    typedef struct packed {
        logic [2:0]  action;
        logic [11:0] addrMode;
        logic [15:0] data;
        logic [7:0]  count;
        logic [1:0]  latency;
    } rowT;

    `include "demodRouterTbTable.svh"

    localparam int watchdogCycles = resetCycles + tableLen * 20;

    logic                                       ck933;
    logic                                       clockCounterEn;
    demodPkg::busReqT                           busReq;
    logic [15:0]                                busRdData;
    logic [3:0]                                 demodMode;
    logic                                       coreReset;
    demodPkg::demodSymT                         demodSym;
    demodPkg::trellisResT                       pcmRes;
    demodPkg::trellisResT                       soqpskRes;
    demodPkg::symFeedT                          pcmFeed;
    demodPkg::symFeedT                          soqpskFeed;
    demodPkg::symFeedT                          multiHFeed;
    demodPkg::dataOutT                          dataOut;
    demodPkg::dacSrcT [numDacs-1:0]             demodDac;
    demodPkg::dacSrcT [numDacs-1:0]             pcmDac;
    demodPkg::dacSrcT [numDacs-1:0]             soqpskDac;
    logic [numDacs-1:0][demodPkg::dacWidth-1:0] dacData;
    // Expected DAC port contents, held between syncs
    logic [numDacs-1:0][demodPkg::dacWidth-1:0] dacModel;

    demodRouter #(
        .verNumber(16'h0103),
        .numDacs  (numDacs)
    ) i_demodRouter (
        .ck933(ck933), .clockCounterEn(clockCounterEn),
        .busReq(busReq), .busRdData(busRdData),
        .demodMode(demodMode), .coreReset(coreReset),
        .demodSym(demodSym), .pcmRes(pcmRes), .soqpskRes(soqpskRes),
        .pcmFeed(pcmFeed), .soqpskFeed(soqpskFeed), .multiHFeed(multiHFeed),
        .dataOut(dataOut),
        .demodDac(demodDac), .pcmDac(pcmDac), .soqpskDac(soqpskDac),
        .dacData(dacData)
    );

    always #(clockPeriod / 2) ck933 = ~ck933;

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // ******************************
    // Bus accesses
    // ******************************
    task automatic writeBus(input logic [11:0] addr, input logic [15:0] data);
        busReq = '{cs: 1'b1, rd: 1'b0, wr: 1'b1, addr: addr, wrData: data};
        @(negedge ck933);
        busReq = '0;
    endtask

    task automatic readBus(input logic [11:0] addr, input logic [15:0] expected);
        busReq = '{cs: 1'b1, rd: 1'b1, wr: 1'b0, addr: addr, wrData: 16'h0000};
        @(negedge ck933);
        busReq = '0;
        checkValue("busRdData", busRdData, expected);
    endtask

    task automatic checkCoreReset(input logic [11:0] addr, input logic [15:0] expCycles);
        int highCycles;
        highCycles = 0;
        checkValue("coreReset", coreReset, 0);
        readBus(addr, 16'h0000);
        // Pulse must already be high on the cycle after the read
        while (coreReset === 1'b1 && highCycles < 32) begin
            highCycles++;
            @(negedge ck933);
        end
        checkValue("coreReset high cycles", highCycles, expCycles);
    endtask

    // ******************************
    // Symbol and DAC streams
    // ******************************
    task automatic runStream(input rowT row);
        demodPkg::demodSymT             symHist [0:maxStream-1];
        demodPkg::trellisResT           pcmHist [0:maxStream-1];
        demodPkg::trellisResT           soqHist [0:maxStream-1];
        demodPkg::dacSrcT [numDacs-1:0] demodDacHist [0:maxStream-1];
        demodPkg::dacSrcT [numDacs-1:0] pcmDacHist [0:maxStream-1];
        demodPkg::dacSrcT [numDacs-1:0] soqDacHist [0:maxStream-1];
        logic [numDacs-1:0][3:0]        sel;
        logic [63:0]                    r;
        logic                           pcmMatch;
        logic                           soqMatch;
        logic                           multiMatch;
        demodPkg::symFeedT              expFeed;
        demodPkg::dataOutT              expData;
        demodPkg::trellisResT           res;
        demodPkg::dacSrcT               src;
        int                             idx;
        sel        = row.data[11:0];
        pcmMatch   = (row.addrMode[3:0] == demodPkg::modePcmTrellis);
        soqMatch   = (row.addrMode[3:0] == demodPkg::modeSoqpsk);
        multiMatch = (row.addrMode[3:0] == demodPkg::modeMultiH);
        writeBus({demodPkg::miscPage, demodPkg::offMode}, {12'h000, row.addrMode[3:0]});
        writeBus({demodPkg::miscPage, demodPkg::offDacSel}, row.data);
        checkValue("demodMode", demodMode, row.addrMode[3:0]);
        // Two trailing zero samples flush the pipeline
        for (int j = 0; j < int'(row.count) + 2; j++) begin
            symHist[j] = '0;
            pcmHist[j] = '0;
            soqHist[j] = '0;
            demodDacHist[j] = '0;
            pcmDacHist[j] = '0;
            soqDacHist[j] = '0;
            if (j < int'(row.count)) begin
                r = {$urandom(), $urandom()};
                symHist[j] = r[40:0];
                pcmHist[j] = r[43:41];
                soqHist[j] = r[46:44];
                for (int ch = 0; ch < numDacs; ch++) begin
                    r = {$urandom(), $urandom()};
                    demodDacHist[j][ch] = r[18:0];
                    pcmDacHist[j][ch] = r[37:19];
                    soqDacHist[j][ch] = r[56:38];
                end
            end
            demodSym  = symHist[j];
            pcmRes    = pcmHist[j];
            soqpskRes = soqHist[j];
            demodDac  = demodDacHist[j];
            pcmDac    = pcmDacHist[j];
            soqpskDac = soqDacHist[j];
            @(negedge ck933);

            // Feeds carry the symbols one cycle later, enables only where the mode matches
            expFeed.iSym    = symHist[j].iSym;
            expFeed.qSym    = symHist[j].qSym;
            expFeed.symEn   = symHist[j].trellisSymSync && pcmMatch;
            expFeed.sym2xEn = symHist[j].iSym2xEn && pcmMatch;
            checkValue("pcmFeed", pcmFeed, expFeed);
            expFeed.symEn   = symHist[j].trellisSymSync && soqMatch;
            expFeed.sym2xEn = symHist[j].iSym2xEn && soqMatch;
            checkValue("soqpskFeed", soqpskFeed, expFeed);
            expFeed.symEn   = symHist[j].trellisSymSync && multiMatch;
            expFeed.sym2xEn = symHist[j].iSym2xEn && multiMatch;
            checkValue("multiHFeed", multiHFeed, expFeed);

            idx = j + 1 - int'(row.latency);
            if (idx >= 0) begin
                if (pcmMatch || soqMatch) begin
                    res = pcmMatch ? pcmHist[idx] : soqHist[idx];
                    expData = {res.symEn, res.sym2xEn, res.decision, res.decision};
                end else begin
                    expData = {symHist[idx].iSymEn, symHist[idx].iSym2xEn,
                               symHist[idx].iBit, symHist[idx].qBit};
                end
                checkValue("dataOut", dataOut, expData);
            end

            // Ports load the sample of the cycle before on its sync
            for (int ch = 0; ch < numDacs; ch++) begin
                if (j > 0) begin
                    // Trellis codes fill the top of the select range
                    if (sel[ch] < demodPkg::dacSelTrellisI) begin
                        src = demodDacHist[j-1][ch];
                    end else if (pcmMatch) begin
                        src = pcmDacHist[j-1][ch];
                    end else begin
                        src = soqDacHist[j-1][ch];
                    end
                    if (src.sync) begin
                        dacModel[ch] = src.data[17:4];
                    end
                end
                checkValue($sformatf("dacData[%0d]", ch), dacData[ch], dacModel[ch]);
            end
        end
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        void'($urandom(32'hcc4c_f3ff));
        ck933          = 1'b0;
        clockCounterEn = 1'b1;
        busReq         = '0;
        demodSym       = '0;
        pcmRes         = '0;
        soqpskRes      = '0;
        demodDac       = '0;
        pcmDac         = '0;
        soqpskDac      = '0;
        dacModel       = '0;
        repeat (resetCycles) @(negedge ck933);
        checkValue("busRdData", busRdData, 0);
        checkValue("demodMode", demodMode, 0);
        checkValue("coreReset", coreReset, 0);
        checkValue("pcmFeed", pcmFeed, 0);
        checkValue("soqpskFeed", soqpskFeed, 0);
        checkValue("multiHFeed", multiHFeed, 0);
        checkValue("dataOut", dataOut, 0);
        checkValue("dacData", dacData, 0);
        clockCounterEn = 1'b0;

        for (int i = 0; i < tableLen; i++) begin
            case (stimTable[i].action)
                actWrite:     writeBus(stimTable[i].addrMode, stimTable[i].data);
                actRead:      readBus(stimTable[i].addrMode, stimTable[i].data);
                actIdle:      repeat (stimTable[i].count) @(negedge ck933);
                actCoreReset: checkCoreReset(stimTable[i].addrMode, stimTable[i].data);
                actStream:    runStream(stimTable[i]);
                default: begin
                    $display("Table row %0d holds an unknown action", i);
                    $display("Simulation finished: FAIL");
                    $fatal(1, "Bad table row");
                end
            endcase
        end
        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout: the table did not complete within %0d cycles", watchdogCycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: sim.f
+incdir+.
demodPkg.sv
miscRegs.sv
symbolRouter.sv
dacRouter.sv
demodRouter.sv
demodRouterTb.sv

// File: Bender.yml
package:
  name: demodRouter

sources:
  - demodPkg.sv
  - miscRegs.sv
  - symbolRouter.sv
  - dacRouter.sv
  - demodRouter.sv
  - target: test
    include_dirs:
      - .
    files:
      - demodRouterTb.sv
